//--- verilog/prbs_link_config.svh
`ifndef PRBS_LINK_CONFIG_SVH
`define PRBS_LINK_CONFIG_SVH

// Fiber lanes on the board
`define NUM_LANES       8

//////////////////////////////
// CCB backplane bus
//////////////////////////////
`define CCB_WIDTH       51
`define CCB_CMD_LSB     2
`define CCB_CMD_WIDTH   6
`define CCB_STROBE_BIT  10

// Command codes decoded from the CCB
`define CMD_BX0         6'h01
`define CMD_RESYNC      6'h03
`define CMD_BXRESET     6'h32

//////////////////////////////
// Boot timing
//////////////////////////////
// clk40 cycles per boot tick
`define BOOT_TICK_DIV   4
// Elapsed tick thresholds per boot phase
`define T_TX_WAIT       20
`define T_RX_WAIT       40
`define T_INJECT        140
`define T_INJECT_DONE   160
`define T_INJECT_CLEAR  180

// First lane shown on the front panel
`define LED_LANE_BASE   4

`endif

//--- verilog/prbs_link_pkg.sv
`default_nettype none

`include "prbs_link_config.svh"

package prbs_link_pkg;

    //////////////////////////////
    // Boot sequencer states
    //////////////////////////////
    typedef enum logic [3:0] {
        RESET             = 4'd0,
        EN_TX             = 4'd1,
        EN_TX_DONE        = 4'd2,
        EN_RX             = 4'd3,
        EN_RX_DONE        = 4'd4,
        PRBS_INJECT       = 4'd5,
        PRBS_INJECT_DONE  = 4'd6,
        PRBS_INJECT_CLEAR = 4'd7,
        EN_PRBS_CK        = 4'd8
    } boot_state_t;

    // One bit per fiber lane
    typedef logic [`NUM_LANES-1:0] lane_vec_t;

    // Per lane error count that sticks at 3
    typedef logic [1:0] err_count_t;
    typedef err_count_t [`NUM_LANES-1:0] err_count_arr_t;

    // Ticks since the last timer clear
    typedef logic [7:0] tick_count_t;

    // Raw CCB bus as seen on the backplane
    typedef logic [`CCB_WIDTH-1:0] ccb_bus_t;

    // Front panel LED field
    typedef logic [7:0] led_t;

endpackage

`default_nettype wire

//--- verilog/ccb_cmd_decoder.sv
`default_nettype none

`include "prbs_link_config.svh"

module ccb_cmd_decoder (
    input  wire                          clk40,
    input  wire                          PRBS_reset,
    input  wire prbs_link_pkg::ccb_bus_t ccb_rx_i,
    output logic                         bx0_o,
    output logic                         resync_o,
    output logic                         bxreset_o
);
    import prbs_link_pkg::*;

    ccb_bus_t                  ccb_q;
    logic [`CCB_CMD_WIDTH-1:0] cmd;
    logic                      cmd_strobe;
    logic                      bx0_dec;
    logic                      resync_dec;
    logic                      bxreset_dec;
    logic                      bx0_dec_d;

    //////////////////////////////
    // Bus capture
    //////////////////////////////
    // Bus idles high on the wire
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            ccb_q <= '1;
        end else begin
            ccb_q <= ccb_rx_i;
        end
    end

    // Command and strobe fields are active low
    assign cmd        = ~ccb_q[`CCB_CMD_LSB +: `CCB_CMD_WIDTH];
    assign cmd_strobe = ~ccb_q[`CCB_STROBE_BIT];

    //////////////////////////////
    // Command decode
    //////////////////////////////
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            bx0_dec     <= 1'b0;
            resync_dec  <= 1'b0;
            bxreset_dec <= 1'b0;
            bx0_dec_d   <= 1'b0;
        end else begin
            bx0_dec     <= cmd_strobe && (cmd == `CMD_BX0);
            resync_dec  <= cmd_strobe && (cmd == `CMD_RESYNC);
            bxreset_dec <= cmd_strobe && (cmd == `CMD_BXRESET);
            // Previous bx0 for edge detect
            bx0_dec_d   <= bx0_dec;
        end
    end

    // Single pulse on the first cycle of bx0
    assign bx0_o     = bx0_dec & ~bx0_dec_d;
    // Resync and bxreset follow the strobe as levels
    assign resync_o  = resync_dec;
    assign bxreset_o = bxreset_dec;

    // The FSM expects at most one command per cycle
    a_one_cmd: assert property (@(posedge clk40) disable iff (PRBS_reset)
        $onehot0({bx0_o, resync_o, bxreset_o}))
    else $error("More than one CCB command strobe in the same cycle");

endmodule

`default_nettype wire

//--- verilog/boot_timer.sv
`default_nettype none

`include "prbs_link_config.svh"

module boot_timer (
    input  wire                      clk40,
    input  wire                      PRBS_reset,
    input  wire                      clear_i,
    output prbs_link_pkg::tick_count_t elapsed_o,
    output logic                     blink_o
);
    import prbs_link_pkg::*;

    localparam int DIV_W = (`BOOT_TICK_DIV > 1) ? $clog2(`BOOT_TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`BOOT_TICK_DIV - 1);
    localparam tick_count_t ELAPSED_MAX = '1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // One tick per BOOT_TICK_DIV cycles
    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            div_cnt   <= '0;
            elapsed_o <= '0;
            blink_o   <= 1'b0;
        end else if (clear_i) begin
            // Restart both divider and tick count
            div_cnt   <= '0;
            elapsed_o <= '0;
        end else begin
            if (tick) begin
                div_cnt <= '0;
                blink_o <= ~blink_o;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // Count holds at the top
            if (tick && (elapsed_o != ELAPSED_MAX)) begin
                elapsed_o <= elapsed_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/link_boot_fsm.sv
`default_nettype none

`include "prbs_link_config.svh"

module link_boot_fsm (
    input  wire                           clk40,
    input  wire                           PRBS_reset,
    input  wire prbs_link_pkg::tick_count_t elapsed_i,
    input  wire prbs_link_pkg::lane_vec_t tx_reset_done_i,
    input  wire prbs_link_pkg::lane_vec_t rx_reset_done_i,
    input  wire                           inject_i,
    input  wire                           bx0_i,
    input  wire                           resync_i,
    input  wire                           bxreset_i,
    output prbs_link_pkg::boot_state_t    state_o,
    output prbs_link_pkg::lane_vec_t      tx_reset_o,
    output prbs_link_pkg::lane_vec_t      rx_reset_o,
    output logic                          timer_clear_o,
    output logic                          latch_clear_o,
    output logic                          count_clear_o,
    output logic                          error_inject_o
);
    import prbs_link_pkg::*;

    boot_state_t state_q;
    boot_state_t state_d;

    //////////////////////////////
    // State register
    //////////////////////////////
    // Resync restarts the boot on the next edge
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            state_q <= RESET;
        end else if (resync_i) begin
            state_q <= RESET;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET:             state_d = EN_TX;
            EN_TX:             if (elapsed_i >= `T_TX_WAIT) state_d = EN_TX_DONE;
            // Wait for every TX lane to come out of reset
            EN_TX_DONE:        if (&tx_reset_done_i) state_d = EN_RX;
            EN_RX:             if (elapsed_i >= `T_RX_WAIT) state_d = EN_RX_DONE;
            EN_RX_DONE:        if (&rx_reset_done_i) state_d = PRBS_INJECT;
            // Injection thresholds run from one timer start
            PRBS_INJECT:       if (elapsed_i >= `T_INJECT) state_d = PRBS_INJECT_DONE;
            PRBS_INJECT_DONE:  if (elapsed_i >= `T_INJECT_DONE) state_d = PRBS_INJECT_CLEAR;
            PRBS_INJECT_CLEAR: if (elapsed_i >= `T_INJECT_CLEAR) state_d = EN_PRBS_CK;
            EN_PRBS_CK:        state_d = EN_PRBS_CK;
            default:           state_d = RESET;
        endcase
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////
    always_comb begin
        tx_reset_o     = '0;
        rx_reset_o     = '0;
        timer_clear_o  = 1'b0;
        latch_clear_o  = 1'b0;
        count_clear_o  = 1'b1;
        error_inject_o = 1'b0;
        case (state_q)
            RESET: begin
                tx_reset_o    = '1;
                rx_reset_o    = '1;
                timer_clear_o = 1'b1;
            end
            EN_TX: begin
                rx_reset_o = '1;
            end
            EN_TX_DONE: begin
                rx_reset_o    = '1;
                timer_clear_o = 1'b1;
            end
            EN_RX: begin
                rx_reset_o = '0;
            end
            // Forced errors start as soon as RX is out of reset
            EN_RX_DONE: begin
                timer_clear_o  = 1'b1;
                error_inject_o = 1'b1;
            end
            PRBS_INJECT: begin
                error_inject_o = 1'b1;
            end
            // Latches clear at the end of the window
            PRBS_INJECT_DONE: begin
                error_inject_o = 1'b1;
                latch_clear_o  = 1'b1;
            end
            PRBS_INJECT_CLEAR: begin
                error_inject_o = 1'b0;
            end
            // Normal checking with CCB control
            EN_PRBS_CK: begin
                timer_clear_o  = 1'b1;
                latch_clear_o  = bxreset_i;
                count_clear_o  = bxreset_i;
                error_inject_o = inject_i | bx0_i;
            end
            default: begin
                tx_reset_o    = '1;
                rx_reset_o    = '1;
                timer_clear_o = 1'b1;
            end
        endcase
    end

    // TX leaves reset only while RX is still held
    a_tx_before_rx: assert property (@(posedge clk40) disable iff (PRBS_reset)
        ((tx_reset_o != '1) && $past(tx_reset_o == '1)) |-> (rx_reset_o == '1))
    else $error("TX reset released while RX reset is not asserted");

endmodule

`default_nettype wire

//--- verilog/error_monitor.sv
`default_nettype none

`include "prbs_link_config.svh"

module error_monitor (
    input  wire                              clk40,
    input  wire                              PRBS_reset,
    input  wire prbs_link_pkg::lane_vec_t    prbs_error_i,
    input  wire                              latch_clear_i,
    input  wire                              count_clear_i,
    output prbs_link_pkg::lane_vec_t         latched_error_o,
    output prbs_link_pkg::err_count_arr_t    err_count_o
);
    import prbs_link_pkg::*;

    localparam err_count_t CNT_MAX = '1;

    // Sticky per lane error flags
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            latched_error_o <= '0;
        end else if (latch_clear_i) begin
            latched_error_o <= '0;
        end else begin
            latched_error_o <= latched_error_o | prbs_error_i;
        end
    end

    //////////////////////////////
    // Error counters
    //////////////////////////////
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            err_count_o <= '0;
        end else if (count_clear_i) begin
            err_count_o <= '0;
        end else begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                // Hold at 3 once reached
                if (prbs_error_i[i] && (err_count_o[i] != CNT_MAX)) begin
                    err_count_o[i] <= err_count_t'(err_count_o[i] + 1'b1);
                end
            end
        end
    end

    // Counts only move down through a clear
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane_chk
        a_no_drop: assert property (@(posedge clk40) disable iff (PRBS_reset)
            !$past(count_clear_i) |-> (err_count_o[g] >= $past(err_count_o[g])))
        else $error("Lane %0d error count dropped without a clear", g);
    end

endmodule

`default_nettype wire

//--- verilog/led_display.sv
`default_nettype none

`include "prbs_link_config.svh"

module led_display (
    input  wire                              clk40,
    input  wire                              PRBS_reset,
    input  wire prbs_link_pkg::boot_state_t  state_i,
    input  wire                              blink_i,
    input  wire prbs_link_pkg::lane_vec_t    latched_error_i,
    input  wire prbs_link_pkg::err_count_arr_t err_count_i,
    output prbs_link_pkg::led_t              led_o
);
    import prbs_link_pkg::*;

    led_t       led_d;
    logic [3:0] lane_flags;

    // Four lanes from the base OR'd with blink
    assign lane_flags = latched_error_i[`LED_LANE_BASE +: 4] | {4{blink_i}};

    //////////////////////////////
    // Phase code per state
    //////////////////////////////
    always_comb begin
        led_d = '0;
        case (state_i)
            RESET:             led_d = 8'b0001_0000;
            EN_TX:             led_d = 8'b0010_0000;
            EN_TX_DONE:        led_d = 8'b0011_0000;
            EN_RX:             led_d = 8'b0100_0000;
            EN_RX_DONE:        led_d = 8'b0101_0000;
            // Injection shows latched lanes in the low nibble
            PRBS_INJECT:       led_d = {4'b0110, lane_flags};
            PRBS_INJECT_DONE:  led_d = {4'b1000, lane_flags};
            PRBS_INJECT_CLEAR: led_d = {4'b0111, lane_flags};
            // Two bits of count per lane
            EN_PRBS_CK:        led_d = err_count_i[`LED_LANE_BASE +: 4] | {8{blink_i}};
            default:           led_d = '0;
        endcase
    end

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            led_o <= '0;
        end else begin
            led_o <= led_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/prbs_link_tester.sv
`default_nettype none

module prbs_link_tester (
    input  wire                                clk40,
    input  wire                                PRBS_reset,
    input  wire prbs_link_pkg::ccb_bus_t       ccb_rx_i,
    input  wire prbs_link_pkg::lane_vec_t      tx_reset_done_i,
    input  wire prbs_link_pkg::lane_vec_t      rx_reset_done_i,
    input  wire prbs_link_pkg::lane_vec_t      prbs_error_i,
    input  wire                                inject_i,
    output wire prbs_link_pkg::lane_vec_t      tx_reset_o,
    output wire prbs_link_pkg::lane_vec_t      rx_reset_o,
    output wire                                prbs_cnt_reset_o,
    output wire                                error_inject_o,
    output wire prbs_link_pkg::boot_state_t    boot_state_o,
    output wire prbs_link_pkg::lane_vec_t      latched_error_o,
    output wire prbs_link_pkg::err_count_arr_t err_count_o,
    output wire prbs_link_pkg::led_t           led_o
);
    import prbs_link_pkg::*;

    // Decoded CCB commands
    wire bx0;
    wire resync;
    wire bxreset;

    // Boot timer
    wire tick_count_t elapsed;
    wire              blink;
    wire              timer_clear;

    wire count_clear;

    //////////////////////////////
    // Command path
    //////////////////////////////
    ccb_cmd_decoder u_ccb_dec (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_rx_i   (ccb_rx_i),
        .bx0_o      (bx0),
        .resync_o   (resync),
        .bxreset_o  (bxreset)
    );

    boot_timer u_timer (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .clear_i    (timer_clear),
        .elapsed_o  (elapsed),
        .blink_o    (blink)
    );

    // Latch clear also resets the transceiver PRBS counters
    link_boot_fsm u_fsm (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .elapsed_i       (elapsed),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .inject_i        (inject_i),
        .bx0_i           (bx0),
        .resync_i        (resync),
        .bxreset_i       (bxreset),
        .state_o         (boot_state_o),
        .tx_reset_o      (tx_reset_o),
        .rx_reset_o      (rx_reset_o),
        .timer_clear_o   (timer_clear),
        .latch_clear_o   (prbs_cnt_reset_o),
        .count_clear_o   (count_clear),
        .error_inject_o  (error_inject_o)
    );

    //////////////////////////////
    // Error reporting
    //////////////////////////////
    error_monitor u_err_mon (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .prbs_error_i    (prbs_error_i),
        .latch_clear_i   (prbs_cnt_reset_o),
        .count_clear_i   (count_clear),
        .latched_error_o (latched_error_o),
        .err_count_o     (err_count_o)
    );

    led_display u_led (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .state_i         (boot_state_o),
        .blink_i         (blink),
        .latched_error_i (latched_error_o),
        .err_count_i     (err_count_o),
        .led_o           (led_o)
    );

endmodule

`default_nettype wire

//--- test/tb_prbs_link_tester.sv
`default_nettype none

`include "prbs_link_config.svh"

module tb_prbs_link_tester;
    import prbs_link_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_STEPS   = 10;
    // Rows that make up one full boot
    localparam int BOOT_STEPS  = 8;
    localparam int SLACK       = 16;
    // Few enough pulses that some lanes stay below the cap
    localparam int NUM_PULSES  = 6;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * `BOOT_TICK_DIV * 200;

    logic           clk40;
    logic           PRBS_reset;
    ccb_bus_t       ccb_rx;
    lane_vec_t      tx_reset_done;
    lane_vec_t      rx_reset_done;
    lane_vec_t      prbs_error;
    logic           inject;
    wire lane_vec_t      tx_reset;
    wire lane_vec_t      rx_reset;
    wire                 prbs_cnt_reset;
    wire                 error_inject;
    wire boot_state_t    boot_state;
    wire lane_vec_t      latched_error;
    wire err_count_arr_t err_count;
    wire led_t           led;

    integer seed = 10490;
    int     checks = 0;
    int     value_errors = 0;
    int     other_errors = 0;

    //////////////////////////////
    // Step table
    //////////////////////////////
    lane_vec_t   step_tx_done [NUM_STEPS];
    lane_vec_t   step_rx_done [NUM_STEPS];
    logic        step_inject  [NUM_STEPS];
    boot_state_t step_state   [NUM_STEPS];
    // Cycle limit for reaching the expected state
    int          step_cycles  [NUM_STEPS];
    lane_vec_t   step_tx_rst  [NUM_STEPS];
    lane_vec_t   step_rx_rst  [NUM_STEPS];
    logic        step_inj_exp [NUM_STEPS];
    lane_vec_t   pulse_table  [NUM_PULSES];

    prbs_link_tester UUT (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .ccb_rx_i        (ccb_rx),
        .tx_reset_done_i (tx_reset_done),
        .rx_reset_done_i (rx_reset_done),
        .prbs_error_i    (prbs_error),
        .inject_i        (inject),
        .tx_reset_o      (tx_reset),
        .rx_reset_o      (rx_reset),
        .prbs_cnt_reset_o(prbs_cnt_reset),
        .error_inject_o  (error_inject),
        .boot_state_o    (boot_state),
        .latched_error_o (latched_error),
        .err_count_o     (err_count),
        .led_o           (led)
    );

    always #(CLK_PERIOD / 2) clk40 = ~clk40;

    // Hard stop in case the DUT never reaches a state
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic state_check(input string name, input boot_state_t got, input boot_state_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic lanes_check(input string name, input lane_vec_t got, input lane_vec_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic counts_check(input string name, input err_count_arr_t got,
                                input err_count_arr_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic led_check(input string name, input led_t got, input led_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////
    // Active low command and strobe, random noise elsewhere
    function automatic ccb_bus_t ccb_word(input logic [5:0] cmd, input logic strobe);
        ccb_bus_t word;
        word = ccb_bus_t'({$random(seed), $random(seed)});
        word[`CCB_CMD_LSB +: 6] = ~cmd;
        word[`CCB_STROBE_BIT]   = ~strobe;
        return word;
    endfunction

    // Front panel phase code per boot state
    function automatic logic [3:0] phase_code(input boot_state_t st);
        case (st)
            RESET:             return 4'b0001;
            EN_TX:             return 4'b0010;
            EN_TX_DONE:        return 4'b0011;
            EN_RX:             return 4'b0100;
            EN_RX_DONE:        return 4'b0101;
            PRBS_INJECT:       return 4'b0110;
            PRBS_INJECT_DONE:  return 4'b1000;
            PRBS_INJECT_CLEAR: return 4'b0111;
            default:           return 4'b0000;
        endcase
    endfunction

    task automatic set_step(input int i, input lane_vec_t txd, input lane_vec_t rxd,
                            input logic inj_in, input boot_state_t st, input int cyc,
                            input lane_vec_t txr, input lane_vec_t rxr, input logic inj_exp);
        step_tx_done[i] = txd;
        step_rx_done[i] = rxd;
        step_inject[i]  = inj_in;
        step_state[i]   = st;
        step_cycles[i]  = cyc;
        step_tx_rst[i]  = txr;
        step_rx_rst[i]  = rxr;
        step_inj_exp[i] = inj_exp;
    endtask

    task automatic build_table();
        set_step(0, 8'h00, 8'h00, 1'b0, EN_TX, SLACK, 8'h00, 8'hFF, 1'b0);
        set_step(1, 8'h00, 8'h00, 1'b0, EN_TX_DONE,
                 `T_TX_WAIT * `BOOT_TICK_DIV + SLACK, 8'h00, 8'hFF, 1'b0);
        set_step(2, 8'hFF, 8'h00, 1'b0, EN_RX, SLACK, 8'h00, 8'h00, 1'b0);
        set_step(3, 8'hFF, 8'h00, 1'b0, EN_RX_DONE,
                 `T_RX_WAIT * `BOOT_TICK_DIV + SLACK, 8'h00, 8'h00, 1'b1);
        set_step(4, 8'hFF, 8'hFF, 1'b0, PRBS_INJECT, SLACK, 8'h00, 8'h00, 1'b1);
        set_step(5, 8'hFF, 8'hFF, 1'b0, PRBS_INJECT_DONE,
                 `T_INJECT * `BOOT_TICK_DIV + SLACK, 8'h00, 8'h00, 1'b1);
        set_step(6, 8'hFF, 8'hFF, 1'b0, PRBS_INJECT_CLEAR,
                 (`T_INJECT_DONE - `T_INJECT) * `BOOT_TICK_DIV + SLACK, 8'h00, 8'h00, 1'b0);
        set_step(7, 8'hFF, 8'hFF, 1'b0, EN_PRBS_CK,
                 (`T_INJECT_CLEAR - `T_INJECT_DONE) * `BOOT_TICK_DIV + SLACK,
                 8'h00, 8'h00, 1'b0);
        // Manual injection follows inject_i while checking
        set_step(8, 8'hFF, 8'hFF, 1'b1, EN_PRBS_CK, SLACK, 8'h00, 8'h00, 1'b1);
        set_step(9, 8'hFF, 8'hFF, 1'b0, EN_PRBS_CK, SLACK, 8'h00, 8'h00, 1'b0);
    endtask

    // Drive one row, wait for its state, then check outputs
    task automatic run_step(input int i);
        int   waited;
        led_t led_seen;
        waited = 0;
        tx_reset_done = step_tx_done[i];
        rx_reset_done = step_rx_done[i];
        inject        = step_inject[i];
        ccb_rx        = ccb_word(6'h00, 1'b0);
        @(negedge clk40);
        while ((boot_state !== step_state[i]) && (waited < step_cycles[i])) begin
            @(negedge clk40);
            waited++;
        end
        if (boot_state !== step_state[i]) begin
            $display("Step %0d: state %0d was not reached within %0d cycles",
                     i, step_state[i], step_cycles[i]);
            other_errors++;
        end else begin
            lanes_check("tx_reset_o", tx_reset, step_tx_rst[i]);
            lanes_check("rx_reset_o", rx_reset, step_rx_rst[i]);
            bit_check("error_inject_o", error_inject, step_inj_exp[i]);
            // Latch clear is only raised at the end of the injection window
            bit_check("prbs_cnt_reset_o", prbs_cnt_reset,
                      step_state[i] == PRBS_INJECT_DONE);
            // LED register lags the state by one cycle
            @(negedge clk40);
            state_check("boot_state_o", boot_state, step_state[i]);
            if (step_state[i] != EN_PRBS_CK) begin
                led_seen = led;
                // Low nibble carries lane flags and blink while injecting
                if (step_state[i] inside {PRBS_INJECT, PRBS_INJECT_DONE, PRBS_INJECT_CLEAR}) begin
                    led_seen[3:0] = 4'h0;
                end
                led_check("led_o", led_seen, {phase_code(step_state[i]), 4'h0});
            end
        end
        @(posedge clk40);
        #5;
    endtask

    ////////////////////////////////
    // Error counting in EN_PRBS_CK
    ////////////////////////////////
    task automatic error_count_test();
        int             hits [`NUM_LANES];
        err_count_arr_t exp_cnt;
        lane_vec_t      exp_latch;
        for (int l = 0; l < `NUM_LANES; l++) begin
            hits[l] = 0;
        end
        for (int p = 0; p < NUM_PULSES; p++) begin
            prbs_error = pulse_table[p];
            ccb_rx     = ccb_word(6'h00, 1'b0);
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (pulse_table[p][l]) begin
                    hits[l]++;
                end
            end
            @(posedge clk40);
            #5;
        end
        prbs_error = '0;
        // Count caps at 3, latch is set by any pulse
        for (int l = 0; l < `NUM_LANES; l++) begin
            exp_cnt[l]   = (hits[l] > 3) ? 2'd3 : err_count_t'(hits[l]);
            exp_latch[l] = (hits[l] > 0);
        end
        @(negedge clk40);
        counts_check("err_count_o", err_count, exp_cnt);
        lanes_check("latched_error_o", latched_error, exp_latch);
        @(posedge clk40);
        #5;
    endtask

    // bx0 held for three cycles still gives a single inject cycle
    task automatic bx0_test();
        int high_cycles;
        high_cycles = 0;
        for (int c = 0; c < 10; c++) begin
            ccb_rx = (c < 3) ? ccb_word(`CMD_BX0, 1'b1) : ccb_word(6'h00, 1'b0);
            @(negedge clk40);
            if (error_inject === 1'b1) begin
                high_cycles++;
            end
            @(posedge clk40);
            #5;
        end
        checks++;
        if (high_cycles != 1) begin
            $display("ERROR at %0t: error_inject_o high cycles = %0d, expected 1",
                     $time, high_cycles);
            value_errors++;
        end
    endtask

    task automatic bxreset_test();
        int waited;
        waited = 0;
        ccb_rx = ccb_word(`CMD_BXRESET, 1'b1);
        @(posedge clk40);
        #5;
        ccb_rx = ccb_word(6'h00, 1'b0);
        @(negedge clk40);
        while ((prbs_cnt_reset !== 1'b1) && (waited < 8)) begin
            @(negedge clk40);
            waited++;
        end
        bit_check("prbs_cnt_reset_o", prbs_cnt_reset, 1'b1);
        // Counts and latches drop on the edge after the clear
        @(negedge clk40);
        counts_check("err_count_o", err_count, '0);
        lanes_check("latched_error_o", latched_error, '0);
        bit_check("prbs_cnt_reset_o", prbs_cnt_reset, 1'b0);
        @(posedge clk40);
        #5;
    endtask

    // Resync restarts the boot from RESET
    task automatic resync_test();
        int waited;
        waited = 0;
        tx_reset_done = '0;
        rx_reset_done = '0;
        ccb_rx = ccb_word(`CMD_RESYNC, 1'b1);
        @(posedge clk40);
        #5;
        ccb_rx = ccb_word(6'h00, 1'b0);
        @(negedge clk40);
        while ((boot_state !== RESET) && (waited < 8)) begin
            @(negedge clk40);
            waited++;
        end
        state_check("boot_state_o", boot_state, RESET);
        @(posedge clk40);
        #5;
        for (int i = 0; i < BOOT_STEPS; i++) begin
            run_step(i);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        clk40         = 1'b0;
        PRBS_reset    = 1'b1;
        ccb_rx        = ccb_word(6'h00, 1'b0);
        tx_reset_done = '0;
        rx_reset_done = '0;
        prbs_error    = '0;
        inject        = 1'b0;
        build_table();
        for (int p = 0; p < NUM_PULSES; p++) begin
            pulse_table[p] = lane_vec_t'($random(seed));
        end

        repeat (8) @(posedge clk40);
        @(negedge clk40);
        state_check("boot_state_o", boot_state, RESET);
        lanes_check("tx_reset_o", tx_reset, '1);
        lanes_check("rx_reset_o", rx_reset, '1);
        bit_check("error_inject_o", error_inject, 1'b0);
        bit_check("prbs_cnt_reset_o", prbs_cnt_reset, 1'b0);
        counts_check("err_count_o", err_count, '0);
        lanes_check("latched_error_o", latched_error, '0);
        @(posedge clk40);
        #5;
        PRBS_reset = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(i);
        end
        error_count_test();
        bx0_test();
        bxreset_test();
        resync_test();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/prbs_link_pkg.sv
verilog/ccb_cmd_decoder.sv
verilog/boot_timer.sv
verilog/link_boot_fsm.sv
verilog/error_monitor.sv
verilog/led_display.sv
verilog/prbs_link_tester.sv
test/tb_prbs_link_tester.sv

//--- Bender.yml
package:
  name: prbs_link_tester

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/prbs_link_pkg.sv
      - verilog/ccb_cmd_decoder.sv
      - verilog/boot_timer.sv
      - verilog/link_boot_fsm.sv
      - verilog/error_monitor.sv
      - verilog/led_display.sv
      - verilog/prbs_link_tester.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_prbs_link_tester.sv
